// ==== mbus_subsys.f ====
+incdir+common
common/mbus_pkg.sv
mbus_rx/mbus_rx_deser.sv
logic/mbus_ctrl_filter.sv
mbus_tx/mbus_tx_ser.sv
logic/mbus_power_seq.sv
logic/mbus_subsys.sv
tb/mbus_subsys_assert.sv
tb/tb_mbus_subsys.sv

// ==== tb/tb_mbus_subsys.sv ====
`default_nettype none

`include "mbus_settings.svh"

module tb_mbus_subsys;
	timeunit 1ns;
	timeprecision 1ps;
	import mbus_pkg::*;

	localparam int LIMIT    = 60 * 200 + 1000;  // Frames times cycles per frame plus margin
	localparam int NBITS    = `MBUS_FRAME_BITS;
	localparam int EV_FAIL  = 0;
	localparam int EV_REQ   = 1;
	localparam int EV_SLEEP = 2;
	localparam int EV_ACK   = 3;
	localparam int EV_SUCC  = 4;

	logic       CLK_EXT;
	logic       RESETn_local;
	logic       clkin;
	logic       din;
	logic       frame_in;
	logic       clkout;
	logic       dout;
	logic       frame_out;
	mbus_wd_t   threshold;
	mbus_msg_t  rx_msg;
	logic       rx_req;
	logic       rx_ack;
	logic       rx_fail;
	mbus_msg_t  tx_msg;
	logic       tx_req;
	logic       tx_ack;
	logic       tx_succ;
	logic       sleep_request;
	logic       external_int;
	logic       lrc_isolate;
	logic       lrc_clkenb;
	logic       lrc_reset;
	logic       lrc_sleep;
	logic       clr_ext_int;
	logic [3:0] lrc;

	int               cycles;
	int               fail_cnt;
	int               req_cnt;
	int               sleep_cnt;
	int               ack_cnt;
	int               succ_cnt;
	int               tx_len;
	int               tx_nbits;
	logic [NBITS-1:0] tx_bits;
	logic             rx_req_q = 1'b0;
	logic             frame_q = 1'b0;
	logic             clkout_q = 1'b0;
	mbus_msg_t        exp_q[$];                 // Host messages still expected

	assign lrc = {lrc_isolate, lrc_clkenb, lrc_reset, lrc_sleep};

	mbus_subsys u_dut (.*);

	initial
	begin
		CLK_EXT = 1'b0;
		forever
			#50 CLK_EXT = ~CLK_EXT;
	end

	// ==============================
	// Monitors and run limit
	// ==============================
	always @(negedge CLK_EXT)
	begin
		cycles++;
		if (cycles > LIMIT)
		begin
			$display("Run hung: tests did not finish within %0d cycles", LIMIT);
			stop_with_fail();
		end
		if (u_dut.u_assert.fail_count != 0)
		begin
			$display("A bound assertion on the DUT failed near %0t ns", $time);
			stop_with_fail();
		end
		if (rx_fail)
			fail_cnt++;
		if (sleep_request)
			sleep_cnt++;
		if (tx_ack)
			ack_cnt++;
		if (tx_succ)
			succ_cnt++;
		if (rx_req && !rx_req_q)
			req_cnt++;
		if (frame_out && !frame_q)
		begin
			tx_len   = 0;
			tx_nbits = 0;
		end
		if (frame_out)
			tx_len++;
		if (frame_out && clkout && !clkout_q)   // Rebuild the sent frame
		begin
			tx_bits = {tx_bits[NBITS-2:0], dout};
			tx_nbits++;
		end
		rx_req_q = rx_req;
		frame_q  = frame_out;
		clkout_q = clkout;
	end

	task automatic stop_with_fail();
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check_msg(input mbus_msg_t got, input mbus_msg_t exp, input string what);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t ns: %s got %h/%h/%b expected %h/%h/%b", $time, what,
				got.addr, got.data, got.broadcast, exp.addr, exp.data, exp.broadcast);
			stop_with_fail();
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, what, got, exp);
			stop_with_fail();
		end
	endtask

	task automatic check_pwr(input logic [3:0] got, input logic [3:0] exp, input string what);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t ns: %s lrc lines %b expected %b", $time, what, got, exp);
			stop_with_fail();
		end
	endtask

	task automatic step();
		@(posedge CLK_EXT);
		#5;
	endtask

	task automatic settle();
		@(negedge CLK_EXT);
		#1;
	endtask

	function automatic int count_of(input int which);
		case (which)
			EV_FAIL:  return fail_cnt;
			EV_REQ:   return req_cnt;
			EV_SLEEP: return sleep_cnt;
			EV_ACK:   return ack_cnt;
			default:  return succ_cnt;
		endcase
	endfunction

	task automatic wait_event(input int which, input int target, input int limit,
		input string what);
		int n;
		n = 0;
		while (count_of(which) < target)
		begin
			settle();
			n++;
			if (n > limit)
			begin
				$display("Timed out after %0d cycles waiting for %s", limit, what);
				stop_with_fail();
			end
		end
	endtask

	// Reference rule: prefix zero means broadcast
	function automatic mbus_msg_t make_msg(input mbus_addr_t addr, input mbus_data_t data);
		mbus_msg_t m;
		m.addr      = addr;
		m.data      = data;
		m.broadcast = (addr[`MBUS_ADDR_WIDTH-1:`MBUS_FUNC_WIDTH] == '0);
		return m;
	endfunction

	function automatic mbus_msg_t rand_msg();
		mbus_addr_t a;
		a = $urandom;
		if ($urandom % 4 == 0)
			a[`MBUS_ADDR_WIDTH-1:`MBUS_FUNC_WIDTH] = '0;
		if (a == {4'h0, `MBUS_CHANNEL_CTRL})    // Keep off the control channel
			a[`MBUS_FUNC_WIDTH-1:0] = 4'h2;
		return make_msg(a, $urandom);
	endfunction

	// ==============================
	// Bus driver, 4 cycles per bit
	// ==============================
	task automatic send_frame(input logic [47:0] bits, input int nbits, input int stall_at,
		input int stall_len);
		step();
		frame_in = 1'b1;
		for (int i = nbits - 1; i >= 0; i--)
		begin
			if (nbits - 1 - i == stall_at)
				repeat (stall_len) step();
			din = bits[i];
			step();
			clkin = 1'b1;
			step();
			step();
			clkin = 1'b0;
			step();
		end
		frame_in = 1'b0;
		din      = 1'b0;
	endtask

	task automatic host_ack();
		step();
		rx_ack = 1'b1;
		settle();
		check_flag(rx_req, 1'b1, "rx_req before rx_ack is seen");
		settle();
		check_flag(rx_req, 1'b0, "rx_req the cycle after rx_ack");
		step();
		rx_ack = 1'b0;
	endtask

	task automatic rx_normal(input mbus_msg_t m);
		int r0;
		int f0;
		int s0;
		r0 = req_cnt;
		f0 = fail_cnt;
		s0 = sleep_cnt;
		exp_q.push_back(m);
		send_frame({8'h00, m.addr, m.data}, NBITS, -1, 0);
		wait_event(EV_REQ, r0 + 1, 20, "rx_req after a good frame");
		check_msg(rx_msg, exp_q.pop_front(), "host message");
		check_flag(fail_cnt == f0, 1'b1, "no rx_fail on a good frame");
		host_ack();
		check_flag(sleep_cnt == s0, 1'b1, "no sleep_request on a host message");
	endtask

	task automatic check_sleep_entry();
		logic [3:0] seq [4];
		seq = '{4'b1000, 4'b1100, 4'b1110, 4'b1111};
		for (int i = 0; i < 4; i++)
		begin
			settle();
			check_pwr(lrc, seq[i], "power down step");
		end
	endtask

	task automatic wake_and_check();
		logic [3:0] seq [4];
		seq = '{4'b1110, 4'b1100, 4'b1000, 4'b0000};
		step();
		external_int = 1'b1;
		settle();
		check_pwr(lrc, 4'b1111, "asleep before external_int is seen");
		for (int i = 0; i < 4; i++)
		begin
			settle();
			check_pwr(lrc, seq[i], "power up step");
			check_flag(clr_ext_int, i == 3, "clr_ext_int on return to awake");
		end
		step();
		external_int = 1'b0;
		settle();
		check_flag(clr_ext_int, 1'b0, "clr_ext_int single pulse");
	endtask

	task automatic rx_ctrl(input mbus_data_t data);
		mbus_msg_t m;
		int        r0;
		int        s0;
		logic      is_sleep;
		m        = make_msg({4'h0, `MBUS_CHANNEL_CTRL}, data);
		is_sleep = (data == `MBUS_SLEEP_CMD);
		r0       = req_cnt;
		s0       = sleep_cnt;
		send_frame({8'h00, m.addr, m.data}, NBITS, -1, 0);
		for (int n = 0; n < 16; n++)
		begin
			settle();
			if (sleep_request)
				check_sleep_entry();
		end
		check_flag(req_cnt == r0, 1'b1, "control broadcast kept from host");
		check_flag(sleep_cnt == s0 + is_sleep, 1'b1, "sleep_request pulse count");
		if (is_sleep)
			wake_and_check();
	endtask

	task automatic rx_bad(input int nbits, input int stall_at, input int stall_len);
		int r0;
		int f0;
		r0 = req_cnt;
		f0 = fail_cnt;
		send_frame({$urandom, $urandom}, nbits, stall_at, stall_len);
		wait_event(EV_FAIL, f0 + 1, 30, "rx_fail after a bad frame");
		repeat (8) settle();
		check_flag(fail_cnt == f0 + 1, 1'b1, "single rx_fail per bad frame");
		check_flag(req_cnt == r0, 1'b1, "no rx_req on a bad frame");
	endtask

	task automatic rx_overflow();
		mbus_msg_t m1;
		mbus_msg_t m2;
		int        r0;
		int        f0;
		m1 = rand_msg();
		m2 = rand_msg();
		r0 = req_cnt;
		f0 = fail_cnt;
		exp_q.push_back(m1);
		send_frame({8'h00, m1.addr, m1.data}, NBITS, -1, 0);
		wait_event(EV_REQ, r0 + 1, 20, "rx_req on first frame");
		send_frame({8'h00, m2.addr, m2.data}, NBITS, -1, 0);
		wait_event(EV_FAIL, f0 + 1, 20, "rx_fail on a frame while rx_req is held");
		check_msg(rx_msg, exp_q.pop_front(), "held message after overflow");
		check_flag(req_cnt == r0 + 1, 1'b1, "one rx_req for two frames");
		host_ack();
	endtask

	task automatic tx_one();
		mbus_msg_t m;
		mbus_msg_t got;
		int        a0;
		int        s0;
		m  = rand_msg();
		a0 = ack_cnt;
		s0 = succ_cnt;
		step();
		tx_msg = m;
		tx_req = 1'b1;
		settle();
		check_flag(tx_ack, 1'b0, "tx_ack before tx_req is seen");
		settle();
		check_flag(tx_ack, 1'b1, "tx_ack one cycle after tx_req");
		check_flag(frame_out, 1'b1, "frame_out rises with tx_ack");
		step();
		tx_req = 1'b0;
		wait_event(EV_SUCC, s0 + 1, 100, "tx_succ");
		check_flag(frame_out, 1'b0, "frame_out low at tx_succ");
		got.addr      = tx_bits[NBITS-1 -: `MBUS_ADDR_WIDTH];
		got.data      = tx_bits[`MBUS_DATA_WIDTH-1:0];
		got.broadcast = m.broadcast;             // Not carried on the bus
		check_msg(got, m, "transmitted frame");
		check_flag(tx_nbits == NBITS, 1'b1, "transmitted bit count");
		check_flag(tx_len == 2 * NBITS, 1'b1, "frame_out length");
		check_flag(ack_cnt == a0 + 1, 1'b1, "one tx_ack per message");
	endtask

	// ==============================
	// Test sequence
	// ==============================
	initial
	begin
		void'($urandom(32'hb7d5e925));
		RESETn_local = 1'b0;
		clkin        = 1'b0;
		din          = 1'b0;
		frame_in     = 1'b0;
		threshold    = 16'd20;
		rx_ack       = 1'b0;
		tx_req       = 1'b0;
		tx_msg       = '0;
		external_int = 1'b0;
		repeat (2) @(posedge CLK_EXT);
		#5;
		RESETn_local = 1'b1;
		settle();
		check_flag(|{rx_req, rx_fail, tx_ack, tx_succ, frame_out, clkout, dout,
			sleep_request, clr_ext_int, lrc}, 1'b0, "outputs low after reset");

		repeat (20)
		begin
			if ($urandom % 5 == 0)
				rx_ctrl(($urandom % 2) ? `MBUS_SLEEP_CMD : ($urandom | 32'h2));
			else
				rx_normal(rand_msg());
		end
		rx_ctrl(`MBUS_SLEEP_CMD);
		repeat (6)
			rx_bad(($urandom % 2) ? 1 + $urandom % 39 : 41 + $urandom % 5, -1, 0);
		repeat (4)
		begin
			threshold = 8 + $urandom % 32;
			rx_bad(NBITS, 1 + $urandom % 39, threshold + 8);
		end
		repeat (2)
			rx_overflow();
		repeat (10)
			tx_one();

		if (u_dut.u_assert.fail_count == 0)
		begin
			$display("Simulation finished: PASS");
			$finish;
		end
		else
			stop_with_fail();
	end

endmodule

`default_nettype wire

// ==== tb/mbus_subsys_assert.sv ====
`default_nettype none

module mbus_subsys_assert (
	input logic                CLK_EXT,
	input logic                RESETn_local,
	input mbus_pkg::mbus_msg_t rx_msg,
	input logic                rx_req,
	input logic                rx_ack,
	input logic                tx_ack,
	input logic                tx_succ,
	input logic                lrc_isolate,
	input logic                lrc_sleep
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;                         // Read by the testbench

	// ==============================
	// Host handshakes
	// ==============================
	rx_hold: assert property (@(posedge CLK_EXT) disable iff (!RESETn_local)
		rx_req && !rx_ack |=> $stable(rx_msg))
	else
	begin
		$error("rx_msg changed while rx_req waited for rx_ack");
		fail_count++;
	end

	ack_pulse: assert property (@(posedge CLK_EXT) disable iff (!RESETn_local)
		tx_ack |=> !tx_ack)
	else
	begin
		$error("tx_ack longer than one cycle");
		fail_count++;
	end

	succ_pulse: assert property (@(posedge CLK_EXT) disable iff (!RESETn_local)
		tx_succ |=> !tx_succ)
	else
	begin
		$error("tx_succ longer than one cycle");
		fail_count++;
	end

	// Sleep only behind isolation
	iso_first: assert property (@(posedge CLK_EXT) disable iff (!RESETn_local)
		$rose(lrc_sleep) |-> lrc_isolate)
	else
	begin
		$error("lrc_sleep rose without lrc_isolate");
		fail_count++;
	end

endmodule

bind mbus_subsys mbus_subsys_assert u_assert (.*);

`default_nettype wire

// ==== logic/mbus_subsys.sv ====
`default_nettype none

module mbus_subsys (
	input  logic                CLK_EXT,
	input  logic                RESETn_local,
	// Serial bus
	input  logic                clkin,
	input  logic                din,
	input  logic                frame_in,
	output logic                clkout,
	output logic                dout,
	output logic                frame_out,
	input  mbus_pkg::mbus_wd_t  threshold,
	// Host receive side
	output mbus_pkg::mbus_msg_t rx_msg,
	output logic                rx_req,
	input  logic                rx_ack,
	output logic                rx_fail,
	// Host transmit side
	input  mbus_pkg::mbus_msg_t tx_msg,
	input  logic                tx_req,
	output logic                tx_ack,
	output logic                tx_succ,
	// Power control
	output logic                sleep_request,
	input  logic                external_int,
	output logic                lrc_isolate,
	output logic                lrc_clkenb,
	output logic                lrc_reset,
	output logic                lrc_sleep,
	output logic                clr_ext_int
);
	import mbus_pkg::*;

	mbus_msg_t msg;
	logic      msg_valid;
	logic      deser_fail;

	mbus_rx_deser u_rx (
		.CLK_EXT      (CLK_EXT),
		.RESETn_local (RESETn_local),
		.clkin        (clkin),
		.din          (din),
		.frame_in     (frame_in),
		.threshold    (threshold),
		.msg          (msg),
		.msg_valid    (msg_valid),
		.rx_fail      (deser_fail)
	);

	mbus_ctrl_filter u_filter (
		.CLK_EXT       (CLK_EXT),
		.RESETn_local  (RESETn_local),
		.msg           (msg),
		.msg_valid     (msg_valid),
		.deser_fail    (deser_fail),
		.rx_msg        (rx_msg),
		.rx_req        (rx_req),
		.rx_ack        (rx_ack),
		.rx_fail       (rx_fail),
		.sleep_request (sleep_request)
	);

	mbus_tx_ser u_tx (
		.CLK_EXT      (CLK_EXT),
		.RESETn_local (RESETn_local),
		.tx_msg       (tx_msg),
		.tx_req       (tx_req),
		.tx_ack       (tx_ack),
		.tx_succ      (tx_succ),
		.clkout       (clkout),
		.dout         (dout),
		.frame_out    (frame_out)
	);

	mbus_power_seq u_pwr (
		.CLK_EXT       (CLK_EXT),
		.RESETn_local  (RESETn_local),
		.sleep_request (sleep_request),
		.external_int  (external_int),
		.lrc_isolate   (lrc_isolate),
		.lrc_clkenb    (lrc_clkenb),
		.lrc_reset     (lrc_reset),
		.lrc_sleep     (lrc_sleep),
		.clr_ext_int   (clr_ext_int)
	);

endmodule

`default_nettype wire

// ==== logic/mbus_power_seq.sv ====
`default_nettype none

module mbus_power_seq (
	input  logic CLK_EXT,
	input  logic RESETn_local,
	input  logic sleep_request,
	input  logic external_int,
	output logic lrc_isolate,
	output logic lrc_clkenb,
	output logic lrc_reset,
	output logic lrc_sleep,
	output logic clr_ext_int
);
	import mbus_pkg::*;

	pwr_state_e state;

	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			state       <= pwr_awake;
			lrc_isolate <= 1'b0;
			lrc_clkenb  <= 1'b0;
			lrc_reset   <= 1'b0;
			lrc_sleep   <= 1'b0;
			clr_ext_int <= 1'b0;
		end
		else
		begin
			clr_ext_int <= 1'b0;
			case (state)
				pwr_awake:
				begin
					if (sleep_request)
					begin
						lrc_isolate <= 1'b1;
						state       <= pwr_iso;
					end
				end
				pwr_iso:
				begin
					lrc_clkenb <= 1'b1;
					state      <= pwr_clk;
				end
				pwr_clk:
				begin
					lrc_reset <= 1'b1;
					state     <= pwr_rst;
				end
				pwr_rst:
				begin
					lrc_sleep <= 1'b1;
					state     <= pwr_asleep;
				end
				pwr_asleep:
				begin
					if (external_int)
					begin
						lrc_sleep <= 1'b0;
						state     <= pwr_wake;
					end
				end
				// Unwind in reverse order, one line per cycle
				pwr_wake:
				begin
					if (lrc_reset)
						lrc_reset <= 1'b0;
					else if (lrc_clkenb)
						lrc_clkenb <= 1'b0;
					else
					begin
						lrc_isolate <= 1'b0;
						clr_ext_int <= 1'b1;
						state       <= pwr_awake;
					end
				end
				default: state <= pwr_awake;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== mbus_tx/mbus_tx_ser.sv ====
`default_nettype none

`include "mbus_settings.svh"

module mbus_tx_ser (
	input  logic                CLK_EXT,
	input  logic                RESETn_local,
	input  mbus_pkg::mbus_msg_t tx_msg,
	input  logic                tx_req,
	output logic                tx_ack,
	output logic                tx_succ,
	output logic                clkout,
	output logic                dout,
	output logic                frame_out
);

	localparam int NBITS = `MBUS_FRAME_BITS;
	localparam int CNT_W = $clog2(NBITS);

	logic [NBITS-1:0] shreg;
	logic [CNT_W-1:0] bit_cnt;
	logic             phase;                   // High half of a bit
	logic             frame_d;
	logic             start;
	logic             last_bit;

	assign start    = tx_req && !frame_out && !tx_ack;
	assign last_bit = (bit_cnt == CNT_W'(NBITS - 1));

	// ==============================
	// Bit timing and framing
	// ==============================
	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			tx_ack    <= 1'b0;
			tx_succ   <= 1'b0;
			clkout    <= 1'b0;
			dout      <= 1'b0;
			frame_out <= 1'b0;
			frame_d   <= 1'b0;
			phase     <= 1'b0;
			bit_cnt   <= '0;
		end
		else
		begin
			tx_ack  <= 1'b0;
			frame_d <= frame_out;
			tx_succ <= frame_d & ~frame_out;    // Cycle after frame_out falls
			if (start)
			begin
				tx_ack    <= 1'b1;
				frame_out <= 1'b1;
				clkout    <= 1'b0;
				dout      <= tx_msg.addr[`MBUS_ADDR_WIDTH-1];
				phase     <= 1'b0;
				bit_cnt   <= '0;
			end
			else if (frame_out)
			begin
				if (!phase)
				begin
					clkout <= 1'b1;
					phase  <= 1'b1;
				end
				else if (last_bit)
				begin
					frame_out <= 1'b0;
					clkout    <= 1'b0;
					dout      <= 1'b0;
					phase     <= 1'b0;
				end
				else
				begin
					clkout  <= 1'b0;
					phase   <= 1'b0;
					dout    <= shreg[NBITS-2];  // Next bit while clkout is low
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge CLK_EXT)
	begin
		if (start)
			shreg <= {tx_msg.addr, tx_msg.data};
		else if (frame_out && phase && !last_bit)
			shreg <= {shreg[NBITS-2:0], 1'b0};
	end

endmodule

`default_nettype wire

// ==== logic/mbus_ctrl_filter.sv ====
`default_nettype none

`include "mbus_settings.svh"

module mbus_ctrl_filter (
	input  logic                CLK_EXT,
	input  logic                RESETn_local,
	input  mbus_pkg::mbus_msg_t msg,
	input  logic                msg_valid,
	input  logic                deser_fail,
	output mbus_pkg::mbus_msg_t rx_msg,
	output logic                rx_req,
	input  logic                rx_ack,
	output logic                rx_fail,
	output logic                sleep_request
);
	import mbus_pkg::*;

	mbus_func_t func;
	logic       ctrl_match;
	logic       accept;
	logic       overflow;
	logic       sleep_req;

	assign func       = msg.addr[`MBUS_FUNC_WIDTH-1:0];
	assign ctrl_match = msg.broadcast && (func == `MBUS_CHANNEL_CTRL);
	assign accept     = msg_valid & ~rx_req;
	assign overflow   = msg_valid & rx_req;      // Holding register still occupied
	assign rx_fail    = deser_fail | overflow;

	// ==============================
	// Host handshake and sleep decode
	// ==============================
	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			rx_req        <= 1'b0;
			sleep_req     <= 1'b0;
			sleep_request <= 1'b0;
		end
		else
		begin
			if (accept && !ctrl_match)
				rx_req <= 1'b1;
			else if (rx_req && rx_ack)
				rx_req <= 1'b0;

			// Control broadcasts are absorbed here
			sleep_req     <= accept && ctrl_match && (msg.data == `MBUS_SLEEP_CMD);
			sleep_request <= sleep_req;         // One register stage late
		end
	end

	// Holding register
	always_ff @(posedge CLK_EXT)
	begin
		if (accept && !ctrl_match)
			rx_msg <= msg;
	end

endmodule

`default_nettype wire

// ==== mbus_rx/mbus_rx_deser.sv ====
`default_nettype none

`include "mbus_settings.svh"

module mbus_rx_deser (
	input  logic                CLK_EXT,
	input  logic                RESETn_local,
	input  logic                clkin,
	input  logic                din,
	input  logic                frame_in,
	input  mbus_pkg::mbus_wd_t  threshold,
	output mbus_pkg::mbus_msg_t msg,
	output logic                msg_valid,
	output logic                rx_fail
);
	import mbus_pkg::*;

	localparam int NBITS  = `MBUS_FRAME_BITS;
	localparam int CNT_W  = $clog2(NBITS + 1) + 1;
	localparam int PFX_W  = `MBUS_ADDR_WIDTH - `MBUS_FUNC_WIDTH;

	rx_state_e          state;
	logic [1:0]         clkin_ff;
	logic [1:0]         din_ff;
	logic [1:0]         frame_ff;
	logic               clkin_d;
	logic               clk_rise;
	logic               frame_s;
	logic               din_s;
	logic [CNT_W-1:0]   bit_cnt;
	mbus_wd_t           wd_cnt;
	logic               wd_expire;
	logic               frame_end;
	logic               len_ok;
	logic [NBITS-1:0]   shreg;
	mbus_addr_t         addr_in;

	// ==============================
	// Bus line synchronizers
	// ==============================
	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			clkin_ff <= '0;
			din_ff   <= '0;
			frame_ff <= '0;
			clkin_d  <= 1'b0;
		end
		else
		begin
			clkin_ff <= {clkin_ff[0], clkin};
			din_ff   <= {din_ff[0], din};
			frame_ff <= {frame_ff[0], frame_in};
			clkin_d  <= clkin_ff[1];
		end
	end

	assign clk_rise  = clkin_ff[1] & ~clkin_d;
	assign din_s     = din_ff[1];
	assign frame_s   = frame_ff[1];
	assign wd_expire = (wd_cnt == threshold);
	assign frame_end = (state == rx_shift) && !frame_s;
	assign len_ok    = (bit_cnt == CNT_W'(NBITS));
	assign addr_in   = shreg[NBITS-1 -: `MBUS_ADDR_WIDTH];

	// ==============================
	// Frame FSM and watchdog
	// ==============================
	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			state     <= rx_idle;
			bit_cnt   <= '0;
			wd_cnt    <= '0;
			msg_valid <= 1'b0;
			rx_fail   <= 1'b0;
		end
		else
		begin
			msg_valid <= 1'b0;
			rx_fail   <= 1'b0;
			case (state)
				rx_idle:
				begin
					if (frame_s)
					begin
						state   <= rx_shift;
						bit_cnt <= '0;
						wd_cnt  <= '0;
					end
				end
				rx_shift:
				begin
					if (!frame_s)
					begin
						msg_valid <= len_ok;
						rx_fail   <= !len_ok;   // Wrong bit count
						state     <= rx_idle;
					end
					else if (clk_rise)
					begin
						if (bit_cnt != '1)
							bit_cnt <= bit_cnt + 1'b1;
						wd_cnt <= '0;
					end
					else if (wd_expire)
					begin
						rx_fail <= 1'b1;        // Stalled frame
						state   <= rx_done;
					end
					else
						wd_cnt <= wd_cnt + 1'b1;
				end
				rx_done:
				begin
					if (!frame_s)
						state <= rx_idle;
				end
				default: state <= rx_idle;
			endcase
		end
	end

	// Payload path
	always_ff @(posedge CLK_EXT)
	begin
		if ((state == rx_shift) && frame_s && clk_rise)
			shreg <= {shreg[NBITS-2:0], din_s};
		if (frame_end && len_ok)
		begin
			msg.addr      <= addr_in;
			msg.data      <= shreg[`MBUS_DATA_WIDTH-1:0];
			msg.broadcast <= (addr_in[`MBUS_ADDR_WIDTH-1 -: PFX_W] == '0);
		end
	end

endmodule

`default_nettype wire

// ==== common/mbus_pkg.sv ====
`default_nettype none

`include "mbus_settings.svh"

package mbus_pkg;

	typedef logic [`MBUS_ADDR_WIDTH-1:0]      mbus_addr_t;
	typedef logic [`MBUS_FUNC_WIDTH-1:0]      mbus_func_t;
	typedef logic [`MBUS_DATA_WIDTH-1:0]      mbus_data_t;
	typedef logic [`MBUS_WATCH_DOG_WIDTH-1:0] mbus_wd_t;

	// One bus message as it travels between blocks
	typedef struct packed
	{
		mbus_addr_t addr;
		mbus_data_t data;
		logic       broadcast;          // Prefix of addr is zero
	} mbus_msg_t;

	typedef enum logic [1:0]
	{
		rx_idle,
		rx_shift,
		rx_done                         // Waiting for frame_in low after an abort
	} rx_state_e;

	typedef enum logic [2:0]
	{
		pwr_awake,
		pwr_iso,
		pwr_clk,
		pwr_rst,
		pwr_asleep,
		pwr_wake
	} pwr_state_e;

endpackage

`default_nettype wire

// ==== common/mbus_settings.svh ====
`ifndef MBUS_SETTINGS_SVH
`define MBUS_SETTINGS_SVH

// ==============================
// Bus field widths
// ==============================
`define MBUS_ADDR_WIDTH       8             // Short address, upper nibble is the prefix
`define MBUS_FUNC_WIDTH       4             // Function or channel field
`define MBUS_DATA_WIDTH       32
`define MBUS_FRAME_BITS       40            // Address then data, MSB first

// ==============================
// Control channel
// ==============================
`define MBUS_CHANNEL_CTRL     4'h1
`define MBUS_SLEEP_CMD        32'h0000_0001 // All layers sleep

// ==============================
// Receiver watchdog
// ==============================
`define MBUS_WATCH_DOG_WIDTH  16

`endif
